// ==== hdl/srio_req_pkg.sv ====
// Shared widths, packet field codes, doorbell codes and state enums of the request path
`default_nettype none

package srio_req_pkg;

    typedef logic [63:0] srio_word_t;
    typedef logic [31:0] srio_user_t;
    typedef logic [15:0] dev_id_t;
    typedef logic [15:0] db_info_t;
    typedef logic [33:0] srio_addr_t;
    typedef logic [7:0]  keep_t;
    typedef logic [7:0]  tsize_t;
    typedef logic [3:0]  ftype_t;

    // Format and transaction types
    localparam ftype_t     FTYPE_DOORBELL = 4'hA;
    localparam ftype_t     FTYPE_NWRITE   = 4'h5;
    localparam logic [3:0] TTYPE_NWRITE   = 4'h4;
    localparam logic [1:0] REQ_PRIO       = 2'd1;

    // Doorbell information codes
    localparam db_info_t DB_SELF_CHECK   = 16'h0001;
    localparam db_info_t DB_TARGET_READY = 16'h0100;
    localparam db_info_t DB_TARGET_BUSY  = 16'h01FF;
    localparam db_info_t DB_INTEG_ROUTE0 = 16'h0003;
    localparam db_info_t DB_INTEG_ROUTE1 = 16'h0002;

    // NWRITE target address per route
    localparam srio_addr_t ADDR_ROUTE0 = 34'h0_8100_0000;
    localparam srio_addr_t ADDR_ROUTE1 = 34'h0_0010_0000;

    // Only responses from this endpoint are accepted
    localparam dev_id_t RESP_SRC_ID = 16'h0001;

    typedef enum logic [2:0] {
        IDLE, CHECK_REQ, CHECK_WAIT, NWR, INTEG_REQ, INTEG_WAIT
    } seq_state_e;

    typedef enum logic {DB_KIND_CHECK, DB_KIND_INTEG} db_kind_e;

    typedef enum logic [1:0] {
        ERR_NONE          = 2'd0,
        ERR_NO_CHECK_RESP = 2'd1,
        ERR_NO_INTEG_ACK  = 2'd2
    } err_type_e;

endpackage

`default_nettype wire

// ==== hdl/ireq_if.sv ====
// Request channel interface with requester, arbiter and sink views
`timescale 1ns/10ps
`default_nettype none

interface ireq_if import srio_req_pkg::*; ();

    logic       valid;
    logic       ready;
    logic       last;
    srio_word_t data;
    keep_t      keep;
    srio_user_t user;

    modport requester (output valid, last, data, keep, user, input ready);

    // Arbiter side of a peer request
    modport arbiter (input valid, last, data, keep, user, output ready);

    modport sink (input valid, last, data, keep, user, output ready);

endinterface

`default_nettype wire

// ==== hdl/beat_if.sv ====
// FIFO read side interface carrying the buffered user beat at the head
`timescale 1ns/10ps
`default_nettype none

interface beat_if import srio_req_pkg::*; ();

    logic       not_empty;
    logic       pop;
    logic       first;
    logic       last;
    keep_t      keep;
    srio_word_t data;
    tsize_t     size;

    modport source (output not_empty, first, last, keep, data, size, input pop);
    modport sink (input not_empty, first, last, keep, data, size, output pop);

endinterface

`default_nettype wire

// ==== hdl/user_beat_fifo.sv ====
// Synchronous register FIFO holding user beats together with their framing and size
`timescale 1ns/10ps
`default_nettype none

module user_beat_fifo import srio_req_pkg::*; #(
    parameter int FIFO_ADDR_W = 9
) (
    input  wire         log_clk,
    input  wire         log_rst,
    input  wire         wr_en_i,
    input  wire         first_i,
    input  wire         last_i,
    input  srio_word_t  data_i,
    input  keep_t       keep_i,
    input  tsize_t      size_i,
    output logic        full_o,
    beat_if.source      rd
);

    localparam int DEPTH   = 2 ** FIFO_ADDR_W;
    localparam int ENTRY_W = 2 + $bits(keep_t) + $bits(srio_word_t) + $bits(tsize_t);

    logic [ENTRY_W-1:0]   mem [DEPTH];
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic                 do_wr;
    logic                 do_rd;

    // Extra pointer bit tells full from empty
    assign full_o = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                    (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);
    assign rd.not_empty = (wr_ptr != rd_ptr);

    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd.pop && rd.not_empty;

    always_ff @(posedge log_clk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= {first_i, last_i, keep_i, data_i, size_i};
        end
    end

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head entry shown without a read cycle
    assign {rd.first, rd.last, rd.keep, rd.data, rd.size} = mem[rd_ptr[FIFO_ADDR_W-1:0]];

endmodule

`default_nettype wire

// ==== hdl/nwr_packetizer.sv ====
// NWRITE packetizer that sends a header beat then streams the buffered data beats
`timescale 1ns/10ps
`default_nettype none

module nwr_packetizer import srio_req_pkg::*; (
    input  wire         log_clk,
    input  wire         log_rst,
    input  wire         nwr_go_i,
    input  wire         target_sel_i,
    input  dev_id_t     src_id_i,
    input  dev_id_t     des_id_i,
    beat_if.sink        rd,
    ireq_if.requester   req,
    output logic        nwr_done_o
);

    logic       data_phase;
    logic       hdr_valid;
    srio_word_t hdr_q;
    srio_addr_t route_addr;
    logic       hdr_load;
    logic       beat_xfer;

    assign route_addr = target_sel_i ? ADDR_ROUTE1 : ADDR_ROUTE0;

    // A new packet starts only at a first-flagged head entry
    assign hdr_load  = !data_phase && !hdr_valid && nwr_go_i && rd.not_empty && rd.first;
    assign beat_xfer = req.valid && req.ready;

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            data_phase <= 1'b0;
            hdr_valid  <= 1'b0;
        end else if (hdr_load) begin
            hdr_valid <= 1'b1;
        end else if (hdr_valid && beat_xfer) begin
            hdr_valid  <= 1'b0;
            data_phase <= 1'b1;
        end else if (data_phase && beat_xfer && rd.last) begin
            data_phase <= 1'b0;
        end
    end

    // TID follows the route bit
    always_ff @(posedge log_clk) begin
        if (hdr_load) begin
            hdr_q <= {7'd0, target_sel_i, FTYPE_NWRITE, TTYPE_NWRITE, 1'b0, REQ_PRIO, 1'b0,
                      rd.size, 2'b00, route_addr};
        end
    end

    assign req.valid = hdr_valid || (data_phase && rd.not_empty);
    assign req.data  = data_phase ? rd.data : hdr_q;
    assign req.keep  = data_phase ? rd.keep : 8'hFF;
    assign req.last  = data_phase && rd.last;
    assign req.user  = {src_id_i, des_id_i};

    // Data beats pop on handshake, stray beats are flushed while idle
    assign rd.pop = (data_phase && beat_xfer) ||
                    (!data_phase && !hdr_valid && !nwr_go_i && rd.not_empty && !rd.first);

    assign nwr_done_o = data_phase && beat_xfer && rd.last;

endmodule

`default_nettype wire

// ==== hdl/doorbell_gen.sv ====
// Doorbell source for the self-check and integration requests
`timescale 1ns/10ps
`default_nettype none

module doorbell_gen import srio_req_pkg::*; (
    input  wire         log_clk,
    input  wire         log_rst,
    input  wire         db_start_i,
    input  db_kind_e    db_kind_i,
    input  wire         target_sel_i,
    input  dev_id_t     src_id_i,
    input  dev_id_t     des_id_i,
    ireq_if.requester   req,
    output logic        db_sent_o
);

    logic       valid_q;
    srio_word_t data_q;
    db_info_t   info;

    always_comb begin
        if (db_kind_i == DB_KIND_CHECK) begin
            info = DB_SELF_CHECK;
        end else begin
            info = target_sel_i ? DB_INTEG_ROUTE1 : DB_INTEG_ROUTE0;
        end
    end

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            valid_q <= 1'b0;
        end else if (db_start_i) begin
            valid_q <= 1'b1;
        end else if (req.ready) begin
            valid_q <= 1'b0;
        end
    end

    // Single beat doorbell, TID fixed at zero
    always_ff @(posedge log_clk) begin
        if (db_start_i) begin
            data_q <= {8'h00, FTYPE_DOORBELL, 4'h0, 1'b0, REQ_PRIO, 1'b0, 12'h000, info, 16'h0000};
        end
    end

    assign req.valid = valid_q;
    assign req.data  = data_q;
    assign req.keep  = 8'hFF;
    assign req.last  = 1'b1;
    assign req.user  = {src_id_i, des_id_i};

    assign db_sent_o = valid_q && req.ready;

endmodule

`default_nettype wire

// ==== hdl/ireq_arbiter.sv ====
// Fixed priority arbiter with packet lock for the outbound request bus
`timescale 1ns/10ps
`default_nettype none

module ireq_arbiter (
    input  wire         log_clk,
    input  wire         log_rst,
    ireq_if.arbiter     db_req,
    ireq_if.arbiter     nwr_req,
    ireq_if.requester   bus_req
);

    logic locked;
    logic sel_nwr_q;
    logic sel_nwr;

    // Doorbell wins when the bus is free
    assign sel_nwr = locked ? sel_nwr_q : !db_req.valid;

    assign bus_req.valid = sel_nwr ? nwr_req.valid : db_req.valid;
    assign bus_req.last  = sel_nwr ? nwr_req.last  : db_req.last;
    assign bus_req.data  = sel_nwr ? nwr_req.data  : db_req.data;
    assign bus_req.keep  = sel_nwr ? nwr_req.keep  : db_req.keep;
    assign bus_req.user  = sel_nwr ? nwr_req.user  : db_req.user;

    assign db_req.ready  = !sel_nwr && bus_req.ready;
    assign nwr_req.ready = sel_nwr && bus_req.ready;

    // Grant holds from the first shown beat until the last one transfers
    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            locked    <= 1'b0;
            sel_nwr_q <= 1'b0;
        end else if (bus_req.valid) begin
            locked    <= !(bus_req.ready && bus_req.last);
            sel_nwr_q <= sel_nwr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/resp_decoder.sv ====
// Inbound doorbell response decoder that also keeps the target route bit
`timescale 1ns/10ps
`default_nettype none

module resp_decoder import srio_req_pkg::*; (
    input  wire         log_clk,
    input  wire         log_rst,
    input  wire         iresp_tvalid_i,
    input  srio_word_t  iresp_tdata_i,
    input  srio_user_t  iresp_tuser_i,
    output logic        check_ready_o,
    output logic        check_busy_o,
    output logic        integ_ack_o,
    output logic        target_sel_o
);

    ftype_t   resp_ftype;
    db_info_t resp_info;
    dev_id_t  resp_src;
    db_info_t integ_code;
    logic     hit;
    logic     ack;

    assign resp_ftype = iresp_tdata_i[55:52];
    assign resp_info  = iresp_tdata_i[31:16];
    assign resp_src   = iresp_tuser_i[31:16];

    assign integ_code = target_sel_o ? DB_INTEG_ROUTE1 : DB_INTEG_ROUTE0;
    assign hit = iresp_tvalid_i && (resp_ftype == FTYPE_DOORBELL) && (resp_src == RESP_SRC_ID);
    assign ack = hit && (resp_info == integ_code);

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            check_ready_o <= 1'b0;
            check_busy_o  <= 1'b0;
            integ_ack_o   <= 1'b0;
            target_sel_o  <= 1'b0;
        end else begin
            check_ready_o <= hit && (resp_info == DB_TARGET_READY);
            check_busy_o  <= hit && (resp_info == DB_TARGET_BUSY);
            integ_ack_o   <= ack;
            // Route flips together with the acknowledge pulse
            target_sel_o  <= target_sel_o ^ ack;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/link_sequencer.sv ====
// Sequencer FSM with timeout for self-check, NWRITE and integration doorbell
`timescale 1ns/10ps
`default_nettype none

module link_sequencer import srio_req_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 65535
) (
    input  wire         log_clk,
    input  wire         log_rst,
    input  wire         self_check_i,
    input  wire         nwr_req_i,
    input  wire         link_initialized_i,
    input  wire         check_ready_i,
    input  wire         check_busy_i,
    input  wire         integ_ack_i,
    input  wire         db_sent_i,
    input  wire         nwr_done_i,
    output logic        db_start_o,
    output db_kind_e    db_kind_o,
    output logic        nwr_go_o,
    output logic        idle_o,
    output logic        nwr_ready_o,
    output logic        nwr_busy_o,
    output logic        error_o,
    output err_type_e   error_type_o
);

    localparam int TIMER_W = $clog2(TIMEOUT_CYCLES + 1);

    seq_state_e         state;
    logic [TIMER_W-1:0] timer_q;
    logic               waiting;
    logic               timeout;

    assign waiting = (state == CHECK_WAIT) || (state == INTEG_WAIT);
    assign timeout = (timer_q == TIMER_W'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            state        <= IDLE;
            timer_q      <= '0;
            db_start_o   <= 1'b0;
            db_kind_o    <= DB_KIND_CHECK;
            nwr_ready_o  <= 1'b0;
            nwr_busy_o   <= 1'b0;
            error_o      <= 1'b0;
            error_type_o <= ERR_NONE;
        end else begin
            // Status and command outputs are single cycle pulses
            db_start_o   <= 1'b0;
            nwr_ready_o  <= 1'b0;
            nwr_busy_o   <= 1'b0;
            error_o      <= 1'b0;
            error_type_o <= ERR_NONE;
            timer_q      <= waiting ? timer_q + 1'b1 : '0;
            case (state)
                IDLE: begin
                    // Self-check goes ahead of a pending write
                    if (link_initialized_i && self_check_i) begin
                        state      <= CHECK_REQ;
                        db_start_o <= 1'b1;
                        db_kind_o  <= DB_KIND_CHECK;
                    end else if (link_initialized_i && nwr_req_i) begin
                        state <= NWR;
                    end
                end
                CHECK_REQ: begin
                    if (db_sent_i) begin
                        state <= CHECK_WAIT;
                    end
                end
                CHECK_WAIT: begin
                    if (check_ready_i) begin
                        nwr_ready_o <= 1'b1;
                        state       <= IDLE;
                    end else if (check_busy_i) begin
                        nwr_busy_o <= 1'b1;
                        state      <= IDLE;
                    end else if (timeout) begin
                        error_o      <= 1'b1;
                        error_type_o <= ERR_NO_CHECK_RESP;
                        state        <= IDLE;
                    end
                end
                NWR: begin
                    if (nwr_done_i) begin
                        state      <= INTEG_REQ;
                        db_start_o <= 1'b1;
                        db_kind_o  <= DB_KIND_INTEG;
                    end
                end
                INTEG_REQ: begin
                    if (db_sent_i) begin
                        state <= INTEG_WAIT;
                    end
                end
                INTEG_WAIT: begin
                    if (integ_ack_i) begin
                        state <= IDLE;
                    end else if (timeout) begin
                        error_o      <= 1'b1;
                        error_type_o <= ERR_NO_INTEG_ACK;
                        state        <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign nwr_go_o = (state == NWR);
    assign idle_o   = (state == IDLE);

endmodule

`default_nettype wire

// ==== hdl/srio_req_top.sv ====
// Top level of the RapidIO request side joining FIFO, peers, arbiter, decoder and sequencer
`timescale 1ns/10ps
`default_nettype none

module srio_req_top import srio_req_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 65535,
    parameter int FIFO_ADDR_W    = 9
) (
    input  wire         log_clk,
    input  wire         log_rst,
    input  dev_id_t     src_id_i,
    input  dev_id_t     des_id_i,
    input  wire         self_check_i,
    input  wire         nwr_req_i,
    input  wire         link_initialized_i,
    output logic        idle_o,
    output logic        nwr_ready_o,
    output logic        nwr_busy_o,
    output logic        nwr_ack_done_o,
    output logic        error_o,
    output err_type_e   error_type_o,
    input  wire         user_tvalid_i,
    input  wire         user_tfirst_i,
    input  wire         user_tlast_i,
    input  srio_word_t  user_tdata_i,
    input  keep_t       user_tkeep_i,
    input  tsize_t      user_tsize_i,
    output logic        user_tready_o,
    output logic        ireq_tvalid_o,
    input  wire         ireq_tready_i,
    output logic        ireq_tlast_o,
    output srio_word_t  ireq_tdata_o,
    output keep_t       ireq_tkeep_o,
    output srio_user_t  ireq_tuser_o,
    input  wire         iresp_tvalid_i,
    input  srio_word_t  iresp_tdata_i,
    input  srio_user_t  iresp_tuser_i,
    output logic        iresp_tready_o
);

    ireq_if db_req ();
    ireq_if nwr_req ();
    ireq_if bus_req ();
    beat_if user_beat ();

    logic     fifo_full;
    logic     db_start;
    db_kind_e db_kind;
    logic     db_sent;
    logic     nwr_go;
    logic     nwr_done;
    logic     check_ready;
    logic     check_busy;
    logic     integ_ack;
    logic     target_sel;

    assign user_tready_o  = !fifo_full;
    assign iresp_tready_o = 1'b1;
    assign nwr_ack_done_o = integ_ack;

    assign ireq_tvalid_o = bus_req.valid;
    assign ireq_tlast_o  = bus_req.last;
    assign ireq_tdata_o  = bus_req.data;
    assign ireq_tkeep_o  = bus_req.keep;
    assign ireq_tuser_o  = bus_req.user;
    assign bus_req.ready = ireq_tready_i;

    user_beat_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) i_fifo (
        .log_clk, .log_rst, .wr_en_i(user_tvalid_i && user_tready_o),
        .first_i(user_tfirst_i), .last_i(user_tlast_i), .data_i(user_tdata_i),
        .keep_i(user_tkeep_i), .size_i(user_tsize_i), .full_o(fifo_full), .rd(user_beat)
    );

    nwr_packetizer i_nwr (
        .log_clk, .log_rst, .nwr_go_i(nwr_go), .target_sel_i(target_sel),
        .src_id_i, .des_id_i, .rd(user_beat), .req(nwr_req), .nwr_done_o(nwr_done)
    );

    doorbell_gen i_db (
        .log_clk, .log_rst, .db_start_i(db_start), .db_kind_i(db_kind),
        .target_sel_i(target_sel), .src_id_i, .des_id_i, .req(db_req), .db_sent_o(db_sent)
    );

    ireq_arbiter i_arb (
        .log_clk, .log_rst, .db_req(db_req), .nwr_req(nwr_req), .bus_req(bus_req)
    );

    resp_decoder i_resp (
        .log_clk, .log_rst, .iresp_tvalid_i, .iresp_tdata_i, .iresp_tuser_i,
        .check_ready_o(check_ready), .check_busy_o(check_busy), .integ_ack_o(integ_ack),
        .target_sel_o(target_sel)
    );

    link_sequencer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_seq (
        .log_clk, .log_rst, .self_check_i, .nwr_req_i, .link_initialized_i,
        .check_ready_i(check_ready), .check_busy_i(check_busy), .integ_ack_i(integ_ack),
        .db_sent_i(db_sent), .nwr_done_i(nwr_done), .db_start_o(db_start),
        .db_kind_o(db_kind), .nwr_go_o(nwr_go), .idle_o, .nwr_ready_o, .nwr_busy_o,
        .error_o, .error_type_o
    );

endmodule

`default_nettype wire

// ==== testbench/tb_srio_req.sv ====
// Testbench with clock, reset, DUT, doorbell target model, compare tasks and directed tests
`timescale 1ns/10ps
`default_nettype none

module tb_srio_req import srio_req_pkg::*; ();

    localparam int      TIMEOUT_CYCLES = 200;
    localparam int      FIFO_ADDR_W    = 4;
    localparam int      BEAT_LIMIT     = 200;
    localparam int      PULSE_LIMIT    = 50;
    localparam int      ERR_LIMIT      = TIMEOUT_CYCLES + 20;
    localparam dev_id_t SRC_ID         = 16'h00A5;
    localparam dev_id_t DES_ID         = 16'h0001;

    logic       log_clk;
    logic       log_rst;
    dev_id_t    src_id_i;
    dev_id_t    des_id_i;
    logic       self_check_i;
    logic       nwr_req_i;
    logic       link_initialized_i;
    logic       idle_o;
    logic       nwr_ready_o;
    logic       nwr_busy_o;
    logic       nwr_ack_done_o;
    logic       error_o;
    err_type_e  error_type_o;
    logic       user_tvalid_i;
    logic       user_tfirst_i;
    logic       user_tlast_i;
    srio_word_t user_tdata_i;
    keep_t      user_tkeep_i;
    tsize_t     user_tsize_i;
    logic       user_tready_o;
    logic       ireq_tvalid_o;
    logic       ireq_tready_i;
    logic       ireq_tlast_o;
    srio_word_t ireq_tdata_o;
    keep_t      ireq_tkeep_o;
    srio_user_t ireq_tuser_o;
    logic       iresp_tvalid_i;
    srio_word_t iresp_tdata_i;
    srio_user_t iresp_tuser_i;
    logic       iresp_tready_o;

    // Random stalls on the request output while set
    logic       backpressure;
    srio_word_t exp_data[$];
    keep_t      exp_keep[$];

    srio_req_top #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES), .FIFO_ADDR_W(FIFO_ADDR_W)) i_dut (
        .log_clk(log_clk), .log_rst(log_rst), .src_id_i(src_id_i), .des_id_i(des_id_i),
        .self_check_i(self_check_i), .nwr_req_i(nwr_req_i),
        .link_initialized_i(link_initialized_i), .idle_o(idle_o), .nwr_ready_o(nwr_ready_o),
        .nwr_busy_o(nwr_busy_o), .nwr_ack_done_o(nwr_ack_done_o), .error_o(error_o),
        .error_type_o(error_type_o), .user_tvalid_i(user_tvalid_i),
        .user_tfirst_i(user_tfirst_i), .user_tlast_i(user_tlast_i),
        .user_tdata_i(user_tdata_i), .user_tkeep_i(user_tkeep_i),
        .user_tsize_i(user_tsize_i), .user_tready_o(user_tready_o),
        .ireq_tvalid_o(ireq_tvalid_o), .ireq_tready_i(ireq_tready_i),
        .ireq_tlast_o(ireq_tlast_o), .ireq_tdata_o(ireq_tdata_o),
        .ireq_tkeep_o(ireq_tkeep_o), .ireq_tuser_o(ireq_tuser_o),
        .iresp_tvalid_i(iresp_tvalid_i), .iresp_tdata_i(iresp_tdata_i),
        .iresp_tuser_i(iresp_tuser_i), .iresp_tready_o(iresp_tready_o)
    );

    initial begin
        log_clk = 1'b0;
        forever #20 log_clk = ~log_clk;
    end

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_word(input string name, input srio_word_t got, input srio_word_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_user(input string name, input srio_user_t got, input srio_user_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_keep(input string name, input keep_t got, input keep_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_err(input string name, input err_type_e got, input err_type_e exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // Doorbell beat as the target sees it with TID zero
    function automatic srio_word_t doorbell_word(input db_info_t info);
        return {8'h00, FTYPE_DOORBELL, 4'h0, 1'b0, REQ_PRIO, 1'b0, 12'h000, info, 16'h0000};
    endfunction

    function automatic srio_word_t nwrite_header(input logic tid, input tsize_t size,
                                                 input srio_addr_t addr);
        return {7'd0, tid, FTYPE_NWRITE, TTYPE_NWRITE, 1'b0, REQ_PRIO, 1'b0, size, 2'b00, addr};
    endfunction

    function automatic logic status_bit(input string name);
        if (name == "idle_o") return idle_o;
        if (name == "nwr_ready_o") return nwr_ready_o;
        if (name == "nwr_busy_o") return nwr_busy_o;
        if (name == "nwr_ack_done_o") return nwr_ack_done_o;
        if (name == "error_o") return error_o;
        return 1'bx;
    endfunction

    // Outputs are sampled on the falling edge
    task automatic wait_high(input string name, input int limit);
        int n;
        n = 0;
        @(negedge log_clk);
        while (status_bit(name) !== 1'b1) begin
            n++;
            if (n > limit) begin
                $display("timeout while waiting for %s to go high", name);
                stop_on_failure();
            end
            @(negedge log_clk);
        end
    endtask

    task automatic recv_beat(output srio_word_t data, output keep_t keep, output logic last,
                             output srio_user_t user);
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        while (!got) begin
            @(posedge log_clk);
            ireq_tready_i <= backpressure ? (($urandom % 2) != 0) : 1'b1;
            @(negedge log_clk);
            if (ireq_tvalid_o && ireq_tready_i) begin
                data = ireq_tdata_o;
                keep = ireq_tkeep_o;
                last = ireq_tlast_o;
                user = ireq_tuser_o;
                got  = 1'b1;
            end
            n++;
            if (!got && n > BEAT_LIMIT) begin
                $display("timeout while waiting for a request beat");
                stop_on_failure();
            end
        end
    endtask

    // Target model that answers with a doorbell from its own device ID
    task automatic answer_doorbell(input db_info_t info);
        @(posedge log_clk);
        iresp_tvalid_i <= 1'b1;
        iresp_tdata_i  <= doorbell_word(info);
        iresp_tuser_i  <= {RESP_SRC_ID, SRC_ID};
        @(posedge log_clk);
        iresp_tvalid_i <= 1'b0;
    endtask

    task automatic push_beat(input logic first, input logic last, input srio_word_t data,
                             input keep_t keep, input tsize_t size);
        int n;
        n = 0;
        @(negedge log_clk);
        while (!user_tready_o) begin
            n++;
            if (n > PULSE_LIMIT) begin
                $display("user stream stayed stalled by a full FIFO");
                stop_on_failure();
            end
            @(negedge log_clk);
        end
        @(posedge log_clk);
        user_tvalid_i <= 1'b1;
        user_tfirst_i <= first;
        user_tlast_i  <= last;
        user_tdata_i  <= data;
        user_tkeep_i  <= keep;
        user_tsize_i  <= size;
        @(posedge log_clk);
        user_tvalid_i <= 1'b0;
    endtask

    task automatic request_self_check();
        @(posedge log_clk);
        self_check_i <= 1'b1;
        @(posedge log_clk);
        self_check_i <= 1'b0;
    endtask

    task automatic request_nwrite();
        @(posedge log_clk);
        nwr_req_i <= 1'b1;
        @(posedge log_clk);
        nwr_req_i <= 1'b0;
    endtask

    task automatic expect_doorbell(input db_info_t info);
        srio_word_t data;
        keep_t      keep;
        logic       last;
        srio_user_t user;
        recv_beat(data, keep, last, user);
        check_word("ireq_tdata_o", data, doorbell_word(info));
        check_user("ireq_tuser_o", user, {SRC_ID, DES_ID});
        check_bit("ireq_tlast_o", last, 1'b1);
    endtask

    // Buffers one random packet and checks header, data and the integration doorbell
    task automatic run_nwrite(input logic route, input db_info_t integ_code);
        int         nbeats;
        int         i;
        tsize_t     size;
        srio_addr_t addr;
        srio_word_t data;
        keep_t      keep;
        logic       last;
        srio_user_t user;
        nbeats = 2 + ($urandom % 5);
        size   = tsize_t'(nbeats * 8 - 1);
        addr   = route ? ADDR_ROUTE1 : ADDR_ROUTE0;
        exp_data.delete();
        exp_keep.delete();
        for (i = 0; i < nbeats; i++) begin
            exp_data.push_back({$urandom, $urandom});
            exp_keep.push_back(keep_t'($urandom));
            push_beat(i == 0, i == nbeats - 1, exp_data[i], exp_keep[i], size);
        end
        request_nwrite();
        recv_beat(data, keep, last, user);
        check_word("ireq_tdata_o", data, nwrite_header(route, size, addr));
        check_user("ireq_tuser_o", user, {SRC_ID, DES_ID});
        check_bit("ireq_tlast_o", last, 1'b0);
        for (i = 0; i < nbeats; i++) begin
            recv_beat(data, keep, last, user);
            check_word("ireq_tdata_o", data, exp_data[i]);
            check_keep("ireq_tkeep_o", keep, exp_keep[i]);
            check_bit("ireq_tlast_o", last, i == nbeats - 1);
            check_user("ireq_tuser_o", user, {SRC_ID, DES_ID});
        end
        expect_doorbell(integ_code);
    endtask

    task automatic test_reset_state();
        @(negedge log_clk);
        check_bit("idle_o", idle_o, 1'b1);
        check_bit("ireq_tvalid_o", ireq_tvalid_o, 1'b0);
        check_bit("error_o", error_o, 1'b0);
        check_err("error_type_o", error_type_o, ERR_NONE);
        check_bit("iresp_tready_o", iresp_tready_o, 1'b1);
        check_bit("nwr_ready_o", nwr_ready_o, 1'b0);
        check_bit("nwr_busy_o", nwr_busy_o, 1'b0);
        check_bit("nwr_ack_done_o", nwr_ack_done_o, 1'b0);
        // Empty FIFO accepts user beats
        check_bit("user_tready_o", user_tready_o, 1'b1);
    endtask

    task automatic test_self_check();
        request_self_check();
        expect_doorbell(DB_SELF_CHECK);
        answer_doorbell(DB_TARGET_READY);
        wait_high("nwr_ready_o", PULSE_LIMIT);
        check_bit("nwr_busy_o", nwr_busy_o, 1'b0);
        wait_high("idle_o", PULSE_LIMIT);
        // Second check answered busy
        request_self_check();
        expect_doorbell(DB_SELF_CHECK);
        answer_doorbell(DB_TARGET_BUSY);
        wait_high("nwr_busy_o", PULSE_LIMIT);
        check_bit("nwr_ready_o", nwr_ready_o, 1'b0);
        wait_high("idle_o", PULSE_LIMIT);
    endtask

    task automatic test_check_timeout();
        request_self_check();
        expect_doorbell(DB_SELF_CHECK);
        wait_high("error_o", ERR_LIMIT);
        check_err("error_type_o", error_type_o, ERR_NO_CHECK_RESP);
        wait_high("idle_o", PULSE_LIMIT);
        check_bit("error_o", error_o, 1'b0);
        check_err("error_type_o", error_type_o, ERR_NONE);
    endtask

    task automatic test_nwrite_route0();
        run_nwrite(1'b0, DB_INTEG_ROUTE0);
        answer_doorbell(DB_INTEG_ROUTE0);
        wait_high("nwr_ack_done_o", PULSE_LIMIT);
        wait_high("idle_o", PULSE_LIMIT);
        check_bit("error_o", error_o, 1'b0);
    endtask

    // Route bit flipped by the previous echo
    task automatic test_nwrite_route1_stalled();
        backpressure = 1'b1;
        run_nwrite(1'b1, DB_INTEG_ROUTE1);
        backpressure = 1'b0;
        @(posedge log_clk);
        ireq_tready_i <= 1'b1;
        wait_high("error_o", ERR_LIMIT);
        check_err("error_type_o", error_type_o, ERR_NO_INTEG_ACK);
        wait_high("idle_o", PULSE_LIMIT);
    endtask

    initial begin
        int seed;
        seed = 70;
        void'($urandom(seed));
        backpressure       = 1'b0;
        log_rst            = 1'b1;
        src_id_i           = SRC_ID;
        des_id_i           = DES_ID;
        self_check_i       = 1'b0;
        nwr_req_i          = 1'b0;
        link_initialized_i = 1'b0;
        user_tvalid_i      = 1'b0;
        user_tfirst_i      = 1'b0;
        user_tlast_i       = 1'b0;
        user_tdata_i       = '0;
        user_tkeep_i       = '0;
        user_tsize_i       = '0;
        ireq_tready_i      = 1'b1;
        iresp_tvalid_i     = 1'b0;
        iresp_tdata_i      = '0;
        iresp_tuser_i      = '0;
        repeat (16) @(posedge log_clk);
        log_rst            <= 1'b0;
        link_initialized_i <= 1'b1;
        test_reset_state();
        test_self_check();
        test_check_timeout();
        test_nwrite_route0();
        test_nwrite_route1_stalled();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/srio_req_pkg.sv
hdl/ireq_if.sv
hdl/beat_if.sv
hdl/user_beat_fifo.sv
hdl/nwr_packetizer.sv
hdl/doorbell_gen.sv
hdl/ireq_arbiter.sv
hdl/resp_decoder.sv
hdl/link_sequencer.sv
hdl/srio_req_top.sv
testbench/tb_srio_req.sv
